//--- sim/l2_mcu_stim.txt
# kind addr id gap err, hex kind: 0 idle, 1 read, 2 read pair, 3 write, 4 overlap, 5 overflow
# err: 0 none, 1 stray rd_ack first, 2 chunks 0 then 2, 3 write data valid withheld
0 000000000 0 8 0
1 000001000 1 2 0
2 000002000 2 3 0
3 000003000 0 2 0
4 000004000 5 3 0
0 000000000 0 4 0
1 1fffff040 7 1 0
3 100000080 0 2 0
2 0a5a5a5c0 6 2 0
4 055555500 3 2 0
3 0000ff000 0 1 0
1 012345680 4 2 0
0 000000000 0 3 1
1 000010000 2 2 2
3 000020000 0 2 3
1 000030000 3 2 0
3 000040000 0 2 0
5 000050000 0 3 0
1 000060000 5 2 0
2 000070000 7 2 0
4 000080000 1 3 0
3 1000c0040 0 1 0
1 0deadbe40 0 2 0
2 0cafe0000 4 2 0
4 123456780 6 2 0
3 0f0f0f0c0 0 2 0
1 0000000c0 1 2 0
3 1fffffe00 0 2 0
2 000090000 3 2 0
0 000000000 0 6 0

//--- all.f
hdl/mcu_if_pkg.sv
hdl/mon_pkg.sv
hdl/req_queue.sv
hdl/mcu_rd_tracker.sv
hdl/mcu_wr_tracker.sv
hdl/mon_event_merge.sv
hdl/l2_mcu_proto_mon.sv
sim/tb_l2_mcu_proto_mon.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_l2_mcu_proto_mon -f all.f \
    && ./obj_dir/Vtb_l2_mcu_proto_mon \
    || exit 1

//--- sim/tb_l2_mcu_proto_mon.sv
// testbench with clock, reset, stimulus file driver, LFSR data, expectation queue and checks
`timescale 1ns/10ps

module tb_l2_mcu_proto_mon;
    import mcu_if_pkg::*;
    import mon_pkg::*;

    localparam int QDEPTH = 4;
    localparam int RD_DLY = 3;
    localparam int WR_DLY = 5;

    typedef struct packed {
        logic [3:0]            kind;
        logic [MCU_ADDR_W-1:0] addr;
        logic [REQ_ID_W-1:0]   id;
        logic [7:0]            gap;
        logic [1:0]            err;
    } txn_t;

    logic                  cmp_clk;
    logic                  flush_reset_complete;
    logic                  rd_req;
    rd_req_t               rd_req_info;
    logic                  rd_ack;
    logic                  rd_data_vld;
    logic [RD_CHUNK_W-1:0] rd_chunk_id;
    rd_data_t              rd_data;
    logic                  wr_req;
    wr_req_t               wr_req_info;
    logic                  wr_ack;
    logic                  wr_data_vld;
    logic [WR_DATA_W-1:0]  wr_data;
    logic                  evt_valid;
    mon_evt_t              evt;
    logic [15:0]           rd_count;
    logic [15:0]           wr_count;
    logic [ERR_W-1:0]      err;

    txn_t                  txn_q [$];
    mon_evt_t              exp_q [$];
    mon_evt_t              exp_evt;
    rd_data_t              rd_buf [RD_CHUNKS];
    logic [WR_DATA_W-1:0]  wr_buf [WR_BEATS];
    logic [31:0]           lfsr = 32'd68818;
    logic [ERR_W-1:0]      exp_err = '0;
    int                    exp_rd_cnt = 0;
    int                    exp_wr_cnt = 0;
    int                    cycle_cnt = 0;
    int                    cycle_limit = 32'h7fff_ffff;
    int                    last_evt_cyc = 0;
    int                    prev_evt_cyc = 0;

    l2_mcu_proto_mon #(
        .QUEUE_DEPTH   (QDEPTH),
        .RD_DATA_DELAY (RD_DLY),
        .WR_DATA_DELAY (WR_DLY)
    ) u_l2_mcu_proto_mon (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .rd_req               (rd_req),
        .rd_req_info          (rd_req_info),
        .rd_ack               (rd_ack),
        .rd_data_vld          (rd_data_vld),
        .rd_chunk_id          (rd_chunk_id),
        .rd_data              (rd_data),
        .wr_req               (wr_req),
        .wr_req_info          (wr_req_info),
        .wr_ack               (wr_ack),
        .wr_data_vld          (wr_data_vld),
        .wr_data              (wr_data),
        .evt_valid            (evt_valid),
        .evt                  (evt),
        .rd_count             (rd_count),
        .wr_count             (wr_count),
        .err                  (err)
    );

    initial cmp_clk = 1'b0;
    always #2 cmp_clk = ~cmp_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
    endfunction

    task automatic get_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr = lfsr_next(lfsr);
            v[b] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic step();
        @(posedge cmp_clk);
        #1;
    endtask

    task automatic gen_read();
        logic [127:0] v;
        for (int c = 0; c < RD_CHUNKS; c++)
        begin
            get_bits(RD_DATA_W, v);
            rd_buf[c].data = v;
            get_bits(RD_ECC_W, v);
            rd_buf[c].ecc = v[RD_ECC_W-1:0];
        end
    endtask

    task automatic gen_write();
        logic [127:0] v;
        for (int b = 0; b < WR_BEATS; b++)
        begin
            get_bits(WR_DATA_W, v);
            wr_buf[b] = v[WR_DATA_W-1:0];
        end
    endtask

    // signatures are the XOR of all chunks or beats.
    function automatic mon_evt_t rd_expect(input logic [MCU_ADDR_W-1:0] addr,
                                           input logic [REQ_ID_W-1:0] id);
        mon_evt_t e;
        e = '0;
        e.kind = EVT_RD;
        e.cmpl.addr = addr;
        e.cmpl.id = id;
        for (int c = 0; c < RD_CHUNKS; c++)
        begin
            e.cmpl.data_sig = e.cmpl.data_sig ^ rd_buf[c].data;
            e.cmpl.ecc_sig = e.cmpl.ecc_sig ^ rd_buf[c].ecc;
        end
        return e;
    endfunction

    function automatic mon_evt_t wr_expect(input logic [MCU_ADDR_W-1:0] addr);
        mon_evt_t e;
        e = '0;
        e.kind = EVT_WR;
        e.cmpl.addr = addr;
        for (int b = 0; b < WR_BEATS; b++)
        begin
            e.cmpl.data_sig = e.cmpl.data_sig ^ RD_DATA_W'(wr_buf[b]);
        end
        return e;
    endfunction

    task automatic send_rd_req(input logic [MCU_ADDR_W-1:0] addr, input logic [REQ_ID_W-1:0] id);
        rd_req = 1'b1;
        rd_req_info.addr = addr;
        rd_req_info.id = id;
        step();
        rd_req = 1'b0;
    endtask

    task automatic pulse_rd_ack();
        rd_ack = 1'b1;
        step();
        rd_ack = 1'b0;
    endtask

    // data trails its strobe by RD_DLY cycles.
    task automatic drive_chunks(input int n, input bit bad_order);
        for (int c = 0; c < n + RD_DLY; c++)
        begin
            rd_data_vld = (c < n);
            rd_chunk_id = (bad_order && c == 1) ? RD_CHUNK_W'(2) : RD_CHUNK_W'(c);
            if (c >= RD_DLY)
                rd_data = rd_buf[c - RD_DLY];
            step();
        end
        rd_data_vld = 1'b0;
    endtask

    task automatic send_wr_req(input logic [MCU_ADDR_W-1:0] addr);
        wr_req = 1'b1;
        wr_req_info.addr = addr;
        step();
        wr_req = 1'b0;
    endtask

    task automatic drive_write(input bit withhold);
        wr_ack = 1'b1;
        step();
        wr_ack = 1'b0;
        repeat (WR_DLY - 1) step();
        for (int b = 0; b < WR_BEATS; b++)
        begin
            wr_data_vld = !withhold;
            wr_data = wr_buf[b];
            step();
        end
        wr_data_vld = 1'b0;
    endtask

    // the queue keeps at most QDEPTH of the n requests.
    task automatic run_reads(input txn_t t, input int n);
        int kept;
        kept = (n > QDEPTH) ? QDEPTH : n;
        for (int k = 0; k < n; k++)
            send_rd_req(t.addr + MCU_ADDR_W'(k * 'h40), t.id + REQ_ID_W'(k));
        if (n > QDEPTH)
            exp_err[ERR_QUEUE_OVERFLOW] = 1'b1;
        repeat (kept) pulse_rd_ack();
        for (int k = 0; k < kept; k++)
        begin
            gen_read();
            if (t.err == 2'd2)
                exp_err[ERR_RD_CHUNK_ORDER] = 1'b1;
            else
                exp_q.push_back(rd_expect(t.addr + MCU_ADDR_W'(k * 'h40), t.id + REQ_ID_W'(k)));
            drive_chunks((t.err == 2'd2) ? 2 : RD_CHUNKS, t.err == 2'd2);
        end
    endtask

    task automatic run_write(input txn_t t);
        send_wr_req(t.addr);
        gen_write();
        if (t.err == 2'd3)
            exp_err[ERR_WR_DATA_MISSING] = 1'b1;
        else
            exp_q.push_back(wr_expect(t.addr));
        drive_write(t.err == 2'd3);
    endtask

    task automatic wait_events();
        while (exp_q.size() != 0)
            step();
    endtask

    // last read chunk and last write beat land in the same cycle.
    task automatic run_overlap(input txn_t t);
        send_rd_req(t.addr, t.id);
        pulse_rd_ack();
        send_wr_req(t.addr + MCU_ADDR_W'('h1000));
        gen_read();
        gen_write();
        exp_q.push_back(rd_expect(t.addr, t.id));
        exp_q.push_back(wr_expect(t.addr + MCU_ADDR_W'('h1000)));
        fork
            drive_write(1'b0);
            begin
                repeat (WR_DLY + 1) step();
                drive_chunks(RD_CHUNKS, 1'b0);
            end
        join
        wait_events();
        check_value("evt_spacing", last_evt_cyc - prev_evt_cyc, 1);
    endtask

    task automatic check_state();
        check_value("rd_count", rd_count, exp_rd_cnt);
        check_value("wr_count", wr_count, exp_wr_cnt);
        check_value("err", err, exp_err);
    endtask

    task automatic load_stim();
        int    fd;
        int    k;
        int    g;
        int    e;
        string line;
        txn_t  t;
        logic [MCU_ADDR_W-1:0] a;
        logic [REQ_ID_W-1:0]   i;
        fd = $fopen("sim/l2_mcu_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file sim/l2_mcu_stim.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "no stimulus");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if ($sscanf(line, "%h %h %h %d %d", k, a, i, g, e) == 5)
                begin
                    t.kind = 4'(k);
                    t.addr = a;
                    t.id = i;
                    t.gap = 8'(g);
                    t.err = 2'(e);
                    txn_q.push_back(t);
                end
            end
            $fclose(fd);
            cycle_limit = txn_q.size() * 40;
        end
    endtask

    always @(posedge cmp_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // registered outputs are stable at the falling edge.
    always @(negedge cmp_clk)
    begin
        if (flush_reset_complete && evt_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("an event appeared with no completion expected");
                $display("TESTBENCH FAILED");
                $fatal(1, "unexpected event");
            end
            else
            begin
                exp_evt = exp_q.pop_front();
                if (exp_evt.kind == EVT_RD)
                    exp_rd_cnt++;
                else
                    exp_wr_cnt++;
                check_value("evt.kind", evt.kind, exp_evt.kind);
                check_value("evt.addr", evt.cmpl.addr, exp_evt.cmpl.addr);
                check_value("evt.id", evt.cmpl.id, exp_evt.cmpl.id);
                check_value("evt.data_sig", evt.cmpl.data_sig, exp_evt.cmpl.data_sig);
                check_value("evt.ecc_sig", evt.cmpl.ecc_sig, exp_evt.cmpl.ecc_sig);
                check_value("rd_count", rd_count, exp_rd_cnt);
                check_value("wr_count", wr_count, exp_wr_cnt);
                prev_evt_cyc = last_evt_cyc;
                last_evt_cyc = cycle_cnt;
            end
        end
    end

    initial
    begin
        flush_reset_complete = 1'b0;
        rd_req = 1'b0;
        rd_req_info = '0;
        rd_ack = 1'b0;
        rd_data_vld = 1'b0;
        rd_chunk_id = '0;
        rd_data = '0;
        wr_req = 1'b0;
        wr_req_info = '0;
        wr_ack = 1'b0;
        wr_data_vld = 1'b0;
        wr_data = '0;
        load_stim();
        repeat (3) @(posedge cmp_clk);
        #1;
        flush_reset_complete = 1'b1;
        foreach (txn_q[n])
        begin
            if (txn_q[n].err == 2'd1)
            begin
                pulse_rd_ack(); // stray ack with nothing pending.
                exp_err[ERR_ACK_NO_REQ] = 1'b1;
            end
            case (txn_q[n].kind)
                4'h1: run_reads(txn_q[n], 1);
                4'h2: run_reads(txn_q[n], 2);
                4'h3: run_write(txn_q[n]);
                4'h4: run_overlap(txn_q[n]);
                4'h5: run_reads(txn_q[n], QDEPTH + 1);
                default: ;
            endcase
            wait_events();
            repeat (txn_q[n].gap + 2) step();
            check_state();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hdl/l2_mcu_proto_mon.sv
// monitor top level with read tracker, write tracker and event merger for one bank
`timescale 1ns/10ps

module l2_mcu_proto_mon #(
    parameter int QUEUE_DEPTH   = 4,
    parameter int RD_DATA_DELAY = 3,
    parameter int WR_DATA_DELAY = 5
) (
    input  logic                              cmp_clk,
    input  logic                              flush_reset_complete,
    input  logic                              rd_req,
    input  mcu_if_pkg::rd_req_t               rd_req_info,
    input  logic                              rd_ack,
    input  logic                              rd_data_vld,
    input  logic [mcu_if_pkg::RD_CHUNK_W-1:0] rd_chunk_id,
    input  mcu_if_pkg::rd_data_t              rd_data,
    input  logic                              wr_req,
    input  mcu_if_pkg::wr_req_t               wr_req_info,
    input  logic                              wr_ack,
    input  logic                              wr_data_vld,
    input  logic [mcu_if_pkg::WR_DATA_W-1:0]  wr_data,
    output logic                              evt_valid,
    output mon_pkg::mon_evt_t                 evt,
    output logic [15:0]                       rd_count,
    output logic [15:0]                       wr_count,
    output logic [mon_pkg::ERR_W-1:0]         err
);
    import mon_pkg::*;

    mon_cmpl_t  rd_cmpl;
    mon_cmpl_t  wr_cmpl;
    logic       rd_cmpl_valid;
    logic       wr_cmpl_valid;
    logic [2:0] rd_err; // overflow, chunk order, ack without request.
    logic [2:0] wr_err; // overflow, data missing, ack without request.

    mcu_rd_tracker #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .RD_DATA_DELAY (RD_DATA_DELAY)
    ) u_mcu_rd_tracker (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .rd_req               (rd_req),
        .rd_req_info          (rd_req_info),
        .rd_ack               (rd_ack),
        .rd_data_vld          (rd_data_vld),
        .rd_chunk_id          (rd_chunk_id),
        .rd_data              (rd_data),
        .cmpl_valid           (rd_cmpl_valid),
        .cmpl                 (rd_cmpl),
        .err_ack_no_req       (rd_err[0]),
        .err_chunk_order      (rd_err[1]),
        .err_overflow         (rd_err[2])
    );

    mcu_wr_tracker #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .WR_DATA_DELAY (WR_DATA_DELAY)
    ) u_mcu_wr_tracker (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .wr_req               (wr_req),
        .wr_req_info          (wr_req_info),
        .wr_ack               (wr_ack),
        .wr_data_vld          (wr_data_vld),
        .wr_data              (wr_data),
        .cmpl_valid           (wr_cmpl_valid),
        .cmpl                 (wr_cmpl),
        .err_ack_no_req       (wr_err[0]),
        .err_data_missing     (wr_err[1]),
        .err_overflow         (wr_err[2])
    );

    mon_event_merge u_mon_event_merge (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .rd_cmpl_valid        (rd_cmpl_valid),
        .rd_cmpl              (rd_cmpl),
        .wr_cmpl_valid        (wr_cmpl_valid),
        .wr_cmpl              (wr_cmpl),
        .rd_err               (rd_err),
        .wr_err               (wr_err),
        .evt_valid            (evt_valid),
        .evt                  (evt),
        .rd_count             (rd_count),
        .wr_count             (wr_count),
        .err                  (err)
    );

endmodule

//--- hdl/mon_event_merge.sv
// ordered event stream, completion counters and sticky error word
`timescale 1ns/10ps

module mon_event_merge (
    input  logic                      cmp_clk,
    input  logic                      flush_reset_complete,
    input  logic                      rd_cmpl_valid,
    input  mon_pkg::mon_cmpl_t        rd_cmpl,
    input  logic                      wr_cmpl_valid,
    input  mon_pkg::mon_cmpl_t        wr_cmpl,
    input  logic [2:0]                rd_err,
    input  logic [2:0]                wr_err,
    output logic                      evt_valid,
    output mon_pkg::mon_evt_t         evt,
    output logic [15:0]               rd_count,
    output logic [15:0]               wr_count,
    output logic [mon_pkg::ERR_W-1:0] err
);
    import mon_pkg::*;

    mon_cmpl_t        hold_cmpl;
    logic             hold_valid;
    logic             wr_emit;
    logic [ERR_W-1:0] err_in;

    // a read always wins the slot; a colliding write waits one cycle.
    assign wr_emit = !rd_cmpl_valid && (hold_valid || wr_cmpl_valid);

    always_comb
    begin
        err_in                      = '0;
        err_in[ERR_ACK_NO_REQ]      = rd_err[0] | wr_err[0];
        err_in[ERR_RD_CHUNK_ORDER]  = rd_err[1];
        err_in[ERR_WR_DATA_MISSING] = wr_err[1];
        err_in[ERR_QUEUE_OVERFLOW]  = rd_err[2] | wr_err[2];
    end

    always_ff @(posedge cmp_clk)
    begin
        if (!flush_reset_complete)
        begin
            evt_valid  <= 1'b0;
            hold_valid <= 1'b0;
            rd_count   <= '0;
            wr_count   <= '0;
            err        <= '0;
        end
        else
        begin
            evt_valid  <= rd_cmpl_valid || wr_emit;
            hold_valid <= rd_cmpl_valid && (wr_cmpl_valid || hold_valid);
            rd_count   <= rd_count + 16'(rd_cmpl_valid);
            wr_count   <= wr_count + 16'(wr_emit);
            err        <= err | err_in;
        end
    end

    always_ff @(posedge cmp_clk)
    begin
        if (wr_cmpl_valid)
        begin
            hold_cmpl <= wr_cmpl;
        end
        if (rd_cmpl_valid)
        begin
            evt.kind <= EVT_RD;
            evt.cmpl <= rd_cmpl;
        end
        else if (wr_emit)
        begin
            evt.kind <= EVT_WR;
            evt.cmpl <= hold_valid ? hold_cmpl : wr_cmpl;
        end
    end

    a_hold_no_wr: assert property (@(posedge cmp_clk) disable iff (!flush_reset_complete)
        hold_valid |-> !wr_cmpl_valid);

endmodule

//--- hdl/mcu_wr_tracker.sv
// write request, ack, data-valid window and write signature tracker
`timescale 1ns/10ps

module mcu_wr_tracker #(
    parameter int QUEUE_DEPTH   = 4,
    parameter int WR_DATA_DELAY = 5
) (
    input  logic                             cmp_clk,
    input  logic                             flush_reset_complete,
    input  logic                             wr_req,
    input  mcu_if_pkg::wr_req_t              wr_req_info,
    input  logic                             wr_ack,
    input  logic                             wr_data_vld,
    input  logic [mcu_if_pkg::WR_DATA_W-1:0] wr_data,
    output logic                             cmpl_valid,
    output mon_pkg::mon_cmpl_t               cmpl,
    output logic                             err_ack_no_req,
    output logic                             err_data_missing,
    output logic                             err_overflow
);
    import mcu_if_pkg::*;

    localparam int WAIT_W = $clog2(WR_DATA_DELAY + 1);
    localparam int BEAT_W = $clog2(WR_BEATS);

    wr_req_t               head;
    logic                  q_empty;
    logic                  q_full;
    logic                  ack_ok;
    logic                  waiting;
    logic                  streaming;
    logic [WAIT_W-1:0]     wait_cnt;
    logic [BEAT_W-1:0]     beat_cnt;
    logic                  check_pt;
    logic                  beat_last;
    logic [WR_DATA_W-1:0]  data_acc;
    logic [MCU_ADDR_W-1:0] act_addr;

    req_queue #(
        .ENTRY_T (wr_req_t),
        .DEPTH   (QUEUE_DEPTH)
    ) u_wr_queue (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .push                 (wr_req),
        .push_data            (wr_req_info),
        .pop                  (ack_ok),
        .head                 (head),
        .empty                (q_empty),
        .full                 (q_full)
    );

    assign ack_ok    = wr_ack && !q_empty && !waiting && !streaming;
    assign check_pt  = waiting && (wait_cnt == '0); // WR_DATA_DELAY cycles after the ack.
    assign beat_last = streaming && (beat_cnt == BEAT_W'(WR_BEATS - 1));

    assign err_ack_no_req   = wr_ack && q_empty;
    assign err_data_missing = check_pt && !wr_data_vld;
    assign err_overflow     = wr_req && q_full;

    always_ff @(posedge cmp_clk)
    begin
        if (!flush_reset_complete)
        begin
            waiting    <= 1'b0;
            streaming  <= 1'b0;
            wait_cnt   <= '0;
            beat_cnt   <= '0;
            cmpl_valid <= 1'b0;
        end
        else
        begin
            cmpl_valid <= beat_last;
            if (ack_ok)
            begin
                waiting  <= 1'b1;
                wait_cnt <= WAIT_W'(WR_DATA_DELAY - 1);
            end
            else if (check_pt)
            begin
                waiting   <= 1'b0;
                streaming <= wr_data_vld; // first beat rides with data valid.
                beat_cnt  <= BEAT_W'(1);
            end
            else if (waiting)
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (beat_last)
            begin
                streaming <= 1'b0;
            end
            else if (streaming)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge cmp_clk)
    begin
        if (ack_ok)
        begin
            act_addr <= head.addr;
        end
        if (check_pt)
        begin
            data_acc <= wr_data;
        end
        else if (streaming)
        begin
            data_acc <= data_acc ^ wr_data;
        end
        if (beat_last)
        begin
            cmpl.addr     <= act_addr;
            cmpl.id       <= '0;
            cmpl.data_sig <= RD_DATA_W'(data_acc ^ wr_data);
            cmpl.ecc_sig  <= '0;
        end
    end

    a_no_ack_active: assert property (@(posedge cmp_clk) disable iff (!flush_reset_complete)
        wr_ack |-> !(waiting || streaming));

endmodule

//--- hdl/mcu_rd_tracker.sv
// read request, ack, chunk sequencing and read signature tracker
`timescale 1ns/10ps

module mcu_rd_tracker #(
    parameter int QUEUE_DEPTH   = 4,
    parameter int RD_DATA_DELAY = 3
) (
    input  logic                              cmp_clk,
    input  logic                              flush_reset_complete,
    input  logic                              rd_req,
    input  mcu_if_pkg::rd_req_t               rd_req_info,
    input  logic                              rd_ack,
    input  logic                              rd_data_vld,
    input  logic [mcu_if_pkg::RD_CHUNK_W-1:0] rd_chunk_id,
    input  mcu_if_pkg::rd_data_t              rd_data,
    output logic                              cmpl_valid,
    output mon_pkg::mon_cmpl_t                cmpl,
    output logic                              err_ack_no_req,
    output logic                              err_chunk_order,
    output logic                              err_overflow
);
    import mcu_if_pkg::*;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    rd_req_t                  head;
    logic                     q_full;
    logic                     q_pop;
    logic                     push_ok;
    logic                     ack_ok;
    logic [CNT_W-1:0]         unacked_cnt;
    logic [CNT_W-1:0]         acked_cnt;
    logic [RD_DATA_DELAY-1:0] vld_dly;
    logic [RD_CHUNK_W-1:0]    id_dly [RD_DATA_DELAY];
    logic                     tap_vld;
    logic [RD_CHUNK_W-1:0]    tap_id;
    logic [RD_CHUNK_W-1:0]    exp_chunk;
    logic                     chunk_ok;
    logic                     chunk_bad;
    logic                     chunk_last;
    logic [RD_DATA_W-1:0]     data_acc;
    logic [RD_ECC_W-1:0]      ecc_acc;

    req_queue #(
        .ENTRY_T (rd_req_t),
        .DEPTH   (QUEUE_DEPTH)
    ) u_rd_queue (
        .cmp_clk              (cmp_clk),
        .flush_reset_complete (flush_reset_complete),
        .push                 (rd_req),
        .push_data            (rd_req_info),
        .pop                  (q_pop),
        .head                 (head),
        .empty                (),
        .full                 (q_full)
    );

    // strobe and chunk id reach the tap when their data is on the bus.
    assign tap_vld    = vld_dly[RD_DATA_DELAY-1];
    assign tap_id     = id_dly[RD_DATA_DELAY-1];
    assign push_ok    = rd_req && !q_full;
    assign ack_ok     = rd_ack && (unacked_cnt != '0);
    assign chunk_ok   = tap_vld && (acked_cnt != '0) && (tap_id == exp_chunk);
    assign chunk_bad  = tap_vld && (acked_cnt != '0) && (tap_id != exp_chunk);
    assign chunk_last = chunk_ok && (exp_chunk == RD_CHUNK_W'(RD_CHUNKS - 1));
    assign q_pop      = chunk_last || chunk_bad; // a bad sequence drops the read.

    assign err_ack_no_req  = (rd_ack && (unacked_cnt == '0)) || (tap_vld && (acked_cnt == '0));
    assign err_chunk_order = chunk_bad;
    assign err_overflow    = rd_req && q_full;

    always_ff @(posedge cmp_clk)
    begin
        id_dly[0] <= rd_chunk_id;
        for (int i = 1; i < RD_DATA_DELAY; i++)
        begin
            id_dly[i] <= id_dly[i-1];
        end
    end

    always_ff @(posedge cmp_clk)
    begin
        if (!flush_reset_complete)
        begin
            vld_dly     <= '0;
            unacked_cnt <= '0;
            acked_cnt   <= '0;
            exp_chunk   <= '0;
            cmpl_valid  <= 1'b0;
        end
        else
        begin
            vld_dly     <= RD_DATA_DELAY'({vld_dly, rd_data_vld});
            unacked_cnt <= unacked_cnt + CNT_W'(push_ok) - CNT_W'(ack_ok);
            acked_cnt   <= acked_cnt + CNT_W'(ack_ok) - CNT_W'(q_pop);
            cmpl_valid  <= chunk_last;
            if (q_pop)
            begin
                exp_chunk <= '0;
            end
            else if (chunk_ok)
            begin
                exp_chunk <= exp_chunk + 1'b1;
            end
        end
    end

    always_ff @(posedge cmp_clk)
    begin
        if (chunk_ok)
        begin
            data_acc <= (exp_chunk == '0) ? rd_data.data : data_acc ^ rd_data.data;
            ecc_acc  <= (exp_chunk == '0) ? rd_data.ecc : ecc_acc ^ rd_data.ecc;
        end
        if (chunk_last)
        begin
            cmpl.addr     <= head.addr; // head still holds this read.
            cmpl.id       <= head.id;
            cmpl.data_sig <= data_acc ^ rd_data.data;
            cmpl.ecc_sig  <= ecc_acc ^ rd_data.ecc;
        end
    end

    a_acked_in_queue: assert property (@(posedge cmp_clk) disable iff (!flush_reset_complete)
        acked_cnt <= u_rd_queue.count);

endmodule

//--- hdl/req_queue.sv
// circular FIFO of pending requests with a generic entry type
`timescale 1ns/10ps

module req_queue #(
    parameter type ENTRY_T = logic,
    parameter int  DEPTH   = 4
) (
    input  logic   cmp_clk,
    input  logic   flush_reset_complete,
    input  logic   push,
    input  ENTRY_T push_data,
    input  logic   pop,
    output ENTRY_T head,
    output logic   empty,
    output logic   full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ENTRY_T           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push && !full; // a push into a full queue is lost.
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge cmp_clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge cmp_clk)
    begin
        if (!flush_reset_complete)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    a_no_pop_empty: assert property (@(posedge cmp_clk) disable iff (!flush_reset_complete)
        pop |-> !empty);

endmodule

//--- hdl/mon_pkg.sv
// monitor event kind, completion and event structs, error bit positions
package mon_pkg;

    typedef enum logic {
        EVT_RD = 1'b0,
        EVT_WR = 1'b1
    } evt_kind_t;

    // write completions carry zero ecc and zero-extended data.
    typedef struct packed {
        logic [mcu_if_pkg::MCU_ADDR_W-1:0] addr;
        logic [mcu_if_pkg::REQ_ID_W-1:0]   id;
        logic [mcu_if_pkg::RD_DATA_W-1:0]  data_sig;
        logic [mcu_if_pkg::RD_ECC_W-1:0]   ecc_sig;
    } mon_cmpl_t;

    typedef struct packed {
        evt_kind_t kind;
        mon_cmpl_t cmpl;
    } mon_evt_t;

    localparam int ERR_W = 4;

    localparam int ERR_ACK_NO_REQ      = 0;
    localparam int ERR_RD_CHUNK_ORDER  = 1;
    localparam int ERR_WR_DATA_MISSING = 2;
    localparam int ERR_QUEUE_OVERFLOW  = 3;

endpackage

//--- hdl/mcu_if_pkg.sv
// MCU port widths plus read request, write request and read data structs
package mcu_if_pkg;

    localparam int MCU_ADDR_W = 33;
    localparam int REQ_ID_W   = 3;
    localparam int RD_DATA_W  = 128;
    localparam int RD_ECC_W   = 28;
    localparam int WR_DATA_W  = 64;
    localparam int RD_CHUNKS  = 4;
    localparam int WR_BEATS   = 8;
    localparam int RD_CHUNK_W = $clog2(RD_CHUNKS);

    // read request as issued by the L2 tag.
    typedef struct packed {
        logic [MCU_ADDR_W-1:0] addr;
        logic [REQ_ID_W-1:0]   id;
    } rd_req_t;

    // eviction write request carries only the address.
    typedef struct packed {
        logic [MCU_ADDR_W-1:0] addr;
    } wr_req_t;

    // one read chunk with its ECC.
    typedef struct packed {
        logic [RD_DATA_W-1:0] data;
        logic [RD_ECC_W-1:0]  ecc;
    } rd_data_t;

endpackage
